// File: ntm_float_pkg.sv
/*
  NTM float package
  Double-precision word layout, operand bundle and shared constants
  for the interpolation gate of the addressing unit
*/

package ntm_float_pkg;

  ////////////////////////////////////////////////////////////
  // Word geometry
  ////////////////////////////////////////////////////////////

  // Full IEEE 754 double word
  localparam int float_size = 64;

  // Biased exponent field
  localparam int exponent_size = 11;

  // Fraction field, hidden bit not stored
  localparam int mantissa_size = 52;

  ////////////////////////////////////////////////////////////
  // Word types
  ////////////////////////////////////////////////////////////

  // Field view of a double, MSB first as in IEEE 754
  typedef struct packed {
    logic                     sign;
    logic [exponent_size-1:0] exponent;
    logic [mantissa_size-1:0] mantissa;
  } float_fields_t;

  // One double seen two ways
  // Raw bits feed $bitstoreal and $realtobits
  // Fields are used for exponent inspection
  typedef union packed {
    logic [float_size-1:0] raw;
    float_fields_t         fields;
  } float_word_t;

  // Operand bundle of one interpolation step
  // gate is g, content is wc, previous is wp
  typedef struct packed {
    float_word_t gate;
    float_word_t content;
    float_word_t previous;
  } interp_operands_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Positive zero, all bits clear
  localparam float_word_t zero_word = '0;

  // All-ones exponent, marks infinity or NaN
  localparam logic [exponent_size-1:0] exponent_max = {exponent_size{1'b1}};

endpackage

// File: scalar_float_multiplier.sv
/*
  Scalar float multiplier
  Two-state behavioral multiplier of two double-precision words,
  start pulse in, one-cycle ready pulse out together with the product
*/

`timescale 1ns/1ps

module scalar_float_multiplier #(
  parameter int data_size = ntm_float_pkg::float_size
) (
  // Global
  input  logic                       CLK,
  input  logic                       RST,

  // Handshake
  input  logic                       start,
  output logic                       ready,

  // Operands
  input  ntm_float_pkg::float_word_t data_a,
  input  ntm_float_pkg::float_word_t data_b,

  // Result
  output ntm_float_pkg::float_word_t product
);

  import ntm_float_pkg::*;

  ////////////////////////////////////////////////////////////
  // State encoding
  ////////////////////////////////////////////////////////////

  // Waiting for start
  localparam logic idle_state = 1'b0;

  // Operands held, product formed on the next edge
  localparam logic multiply_state = 1'b1;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM state
  logic state;

  // Start honored only while idle
  logic accept;

  // Captured operands in simulator arithmetic
  real operand_a;
  real operand_b;

  // Product as a raw bit pattern
  logic [data_size-1:0] product_bits;

  ////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////

  // A start during multiply_state is dropped
  assign accept = start && (state == idle_state);

  // Operand capture at the start edge
  always_ff @(posedge CLK) begin
    if (accept) begin
      operand_a <= $bitstoreal(data_a.raw);
      operand_b <= $bitstoreal(data_b.raw);
    end
  end

  // Real product of the held operands
  assign product_bits = $realtobits(operand_a * operand_b);

  // Control and result register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= idle_state;
      ready   <= 1'b0;
      product <= zero_word;
    end else begin
      case (state)
        idle_state: begin
          // Ready lasts a single cycle
          ready <= 1'b0;
          if (accept) begin
            state <= multiply_state;
          end
        end
        multiply_state: begin
          // Product and ready leave together
          product.raw <= product_bits;
          ready       <= 1'b1;
          state       <= idle_state;
        end
        default: begin
          state <= idle_state;
        end
      endcase
    end
  end

endmodule

// File: scalar_float_combiner.sv
/*
  Scalar float combiner
  Joins the two gate products, forms wp + g*wc - g*wp and flags
  an all-ones exponent in the result as overflow
*/

`timescale 1ns/1ps

module scalar_float_combiner #(
  parameter int data_size = ntm_float_pkg::float_size
) (
  // Global
  input  logic                       CLK,
  input  logic                       RST,

  // Step start, same pulse as the multipliers
  input  logic                       start,

  // Previous weight, latched on start
  input  ntm_float_pkg::float_word_t previous,

  // Products and their ready pulses
  input  ntm_float_pkg::float_word_t product_content,
  input  ntm_float_pkg::float_word_t product_previous,
  input  logic                       ready_content,
  input  logic                       ready_previous,

  // Result
  output logic                       ready,
  output ntm_float_pkg::float_word_t weight,
  output logic                       overflow
);

  import ntm_float_pkg::*;

  ////////////////////////////////////////////////////////////
  // State encoding
  ////////////////////////////////////////////////////////////

  // Waiting for start
  localparam logic idle_state = 1'b0;

  // Collecting products until both are in
  localparam logic join_state = 1'b1;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM state
  logic state;

  // Start honored only while idle
  logic accept;

  // Arrival flags, one per product
  logic content_arrived;
  logic previous_arrived;
  logic both_arrived;

  // Held operands of the sum
  float_word_t previous_held;
  float_word_t content_held;
  float_word_t previous_product_held;

  // Sum in simulator arithmetic
  real previous_real;
  real content_real;
  real previous_product_real;
  real sum_real;

  // Sum as raw bits and as fields
  logic [data_size-1:0] sum_bits;
  float_word_t          sum_word;
  logic                 sum_overflow;

  ////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////

  assign accept       = start && (state == idle_state);
  assign both_arrived = content_arrived && previous_arrived;

  // Payload capture
  // Each product is taken when its own ready shows up
  always_ff @(posedge CLK) begin
    if (accept) begin
      previous_held <= previous;
    end
    if ((state == join_state) && ready_content) begin
      content_held <= product_content;
    end
    if ((state == join_state) && ready_previous) begin
      previous_product_held <= product_previous;
    end
  end

  // Interpolated sum, wp first, then + g*wc, then - g*wp
  always_comb begin
    previous_real         = $bitstoreal(previous_held.raw);
    content_real          = $bitstoreal(content_held.raw);
    previous_product_real = $bitstoreal(previous_product_held.raw);
    sum_real              = (previous_real + content_real) - previous_product_real;
  end

  assign sum_bits = $realtobits(sum_real);
  assign sum_word = float_word_t'(sum_bits);

  // Infinity or NaN in the result
  assign sum_overflow = (sum_word.fields.exponent == exponent_max);

  // Control and result register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state            <= idle_state;
      content_arrived  <= 1'b0;
      previous_arrived <= 1'b0;
      ready            <= 1'b0;
      weight           <= zero_word;
      overflow         <= 1'b0;
    end else begin
      case (state)
        idle_state: begin
          ready <= 1'b0;
          if (accept) begin
            // Fresh step, nothing arrived yet
            content_arrived  <= 1'b0;
            previous_arrived <= 1'b0;
            state            <= join_state;
          end
        end
        join_state: begin
          if (both_arrived) begin
            // One edge after the join
            weight   <= sum_word;
            overflow <= sum_overflow;
            ready    <= 1'b1;
            state    <= idle_state;
          end else begin
            // Products may come in separate cycles
            if (ready_content) begin
              content_arrived <= 1'b1;
            end
            if (ready_previous) begin
              previous_arrived <= 1'b1;
            end
          end
        end
        default: begin
          state <= idle_state;
        end
      endcase
    end
  end

endmodule

// File: scalar_float_interpolation.sv
/*
  Scalar float interpolation gate
  NTM addressing step w = wp + g*wc - g*wp, two parallel multipliers
  feeding one combiner, start to ready in three cycles
*/

`timescale 1ns/1ps

module scalar_float_interpolation #(
  parameter int data_size = ntm_float_pkg::float_size
) (
  // Global
  input  logic                            CLK,
  input  logic                            RST,

  // Handshake
  input  logic                            start,
  output logic                            ready,

  // Gate, content weight and previous weight
  input  ntm_float_pkg::interp_operands_t operands,

  // Interpolated weight
  output ntm_float_pkg::float_word_t      weight,
  output logic                            overflow
);

  import ntm_float_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Gate times content weight
  float_word_t product_content;
  logic        ready_content;

  // Gate times previous weight
  float_word_t product_previous;
  logic        ready_previous;

  ////////////////////////////////////////////////////////////
  // Multipliers
  ////////////////////////////////////////////////////////////

  // Both see the same start and finish in the same cycle
  scalar_float_multiplier #(
    .data_size(data_size)
  ) multiplier_content (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .ready  (ready_content),
    .data_a (operands.gate),
    .data_b (operands.content),
    .product(product_content)
  );

  scalar_float_multiplier #(
    .data_size(data_size)
  ) multiplier_previous (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .ready  (ready_previous),
    .data_a (operands.gate),
    .data_b (operands.previous),
    .product(product_previous)
  );

  ////////////////////////////////////////////////////////////
  // Combiner
  ////////////////////////////////////////////////////////////

  // Latches wp on start, waits for both products
  scalar_float_combiner #(
    .data_size(data_size)
  ) combiner (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .previous        (operands.previous),
    .product_content (product_content),
    .product_previous(product_previous),
    .ready_content   (ready_content),
    .ready_previous  (ready_previous),
    .ready           (ready),
    .weight          (weight),
    .overflow        (overflow)
  );

endmodule

// File: scalar_float_interpolation_tb.sv
/*
  Testbench of the scalar float interpolation gate
  Directed and random vectors checked against a real-arithmetic reference
*/

`timescale 1ns/1ps

module scalar_float_interpolation_tb;

  import ntm_float_pkg::*;

  ////////////////////////////////////////////////////////////
  // Constants and types
  ////////////////////////////////////////////////////////////

  localparam int          clock_period = 8;
  localparam int          vector_count = 200;
  localparam logic [31:0] lcg_seed     = 32'd31058;

  // Sampling edge of start to the edge that raises ready
  localparam int latency = 3;

  // About 220 transactions of at most 8 cycles, reset, then margin
  localparam int max_cycles = 3000;

  // Expected DUT outputs for one step
  typedef struct packed {
    float_word_t weight;
    logic        overflow;
  } result_t;

  // Queue entry, result plus the cycle where ready must show
  typedef struct packed {
    result_t     result;
    logic [31:0] ready_cycle;
  } expected_t;

  ////////////////////////////////////////////////////////////
  // Signals and bookkeeping
  ////////////////////////////////////////////////////////////

  logic             CLK = 1'b0;
  logic             RST;
  logic             start;
  interp_operands_t operands;
  logic             ready;
  float_word_t      weight;
  logic             overflow;

  expected_t   pending[$];
  int          cycle_count;
  int          issued_count;
  int          completed_count;
  int          check_count;
  int          value_errors;
  int          protocol_errors;
  logic        ready_prev = 1'b0;
  logic [31:0] lcg_state  = lcg_seed;

  scalar_float_interpolation #(
    .data_size(float_size)
  ) scalar_float_interpolation_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .ready   (ready),
    .operands(operands),
    .weight  (weight),
    .overflow(overflow)
  );

  // Free-running clock, low at time zero
  initial begin
    forever #(clock_period / 2) CLK = ~CLK;
  end

  // Rising edges seen so far
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Uniform in [-1, 1), upper LCG bits only
  function automatic real random_fraction();
    logic [31:0] r;
    r = next_random();
    return (real'(r[31:9]) / 4194304.0) - 1.0;
  endfunction

  function automatic interp_operands_t make_operands(input real g, input real c, input real p);
    interp_operands_t ops;
    ops.gate.raw     = $realtobits(g);
    ops.content.raw  = $realtobits(c);
    ops.previous.raw = $realtobits(p);
    return ops;
  endfunction

  // w = (wp + g*wc) - g*wp, overflow on an all-ones exponent
  function automatic result_t reference_result(input interp_operands_t ops);
    real     g;
    real     c;
    real     p;
    real     gc;
    real     gp;
    result_t r;
    g  = $bitstoreal(ops.gate.raw);
    c  = $bitstoreal(ops.content.raw);
    p  = $bitstoreal(ops.previous.raw);
    gc = g * c;
    gp = g * p;
    r.weight.raw = $realtobits((p + gc) - gp);
    r.overflow   = &r.weight.fields.exponent;
    return r;
  endfunction

  task automatic check_value(input string label, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("error at %0d ns: %s mismatch, got %h, expected %h",
               $time, label, actual, expected);
    end
  endtask

  task automatic report_protocol(input string message);
    protocol_errors++;
    $display("Protocol problem at %0d ns: %s", $time, message);
  endtask

  task automatic check_idle_outputs();
    check_value("ready at reset", 64'(ready), 64'd0);
    check_value("overflow at reset", 64'(overflow), 64'd0);
    check_value("weight at reset", weight, 64'd0);
  endtask

  // Called at a falling edge, start is sampled at the next rising edge
  task automatic drive_start(input interp_operands_t ops);
    expected_t entry;
    entry.result      = reference_result(ops);
    entry.ready_cycle = cycle_count + 1 + latency;
    pending.push_back(entry);
    issued_count++;
    start    = 1'b1;
    operands = ops;
  endtask

  // Returns at the falling edge where the result was taken
  task automatic wait_result();
    wait (completed_count == issued_count);
  endtask

  task automatic run_vector(input interp_operands_t ops);
    drive_start(ops);
    @(negedge CLK);
    start = 1'b0;
    wait_result();
  endtask

  task automatic run_reals(input real g, input real c, input real p);
    run_vector(make_operands(g, c, p));
  endtask

  ////////////////////////////////////////////////////////////
  // Comparing process, samples at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin : compare_results
    expected_t head;
    if (!RST) begin
      if (ready && ready_prev) begin
        report_protocol("ready stayed high for more than one cycle");
      end else if (ready) begin
        if (pending.size() == 0) begin
          report_protocol("ready pulsed with no start waiting for a result");
        end else begin
          head = pending.pop_front();
          check_value("weight", weight, head.result.weight);
          check_value("overflow", 64'(overflow), 64'(head.result.overflow));
          check_value("ready cycle", 64'(cycle_count), 64'(head.ready_cycle));
          completed_count++;
        end
      end else if ((pending.size() != 0) && (cycle_count > pending[0].ready_cycle)) begin
        // Give up on this step so the stimulus can go on
        report_protocol("no ready pulse came for a started transaction");
        void'(pending.pop_front());
        completed_count++;
      end
    end
    ready_prev = ready;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    interp_operands_t ops;
    result_t          ref_result;
    RST      = 1'b1;
    start    = 1'b0;
    operands = '0;

    // Reset held for three cycles, outputs quiet throughout
    repeat (3) begin
      @(negedge CLK);
      check_idle_outputs();
    end
    RST = 1'b0;
    @(negedge CLK);
    check_idle_outputs();

    // Gate zero keeps the previous weight
    ops        = make_operands(0.0, -0.9, 0.45);
    ref_result = reference_result(ops);
    check_value("gate zero reference", ref_result.weight, $realtobits(0.45));
    run_vector(ops);
    run_reals(0.0, 0.7, 0.3);

    // Gate one, content path
    run_reals(1.0, 0.6, 0.9);
    run_reals(1.0, -0.35, 0.1);

    // Hand-picked values
    run_reals(0.25, 0.8, 0.2);
    run_reals(0.5, -0.5, 0.5);
    run_reals(0.75, 0.125, -0.625);

    // g*wc alone overflows
    ops        = make_operands(4.0, 1.7e308, 1.0);
    ref_result = reference_result(ops);
    check_value("infinity reference", ref_result.weight, 64'h7ff0_0000_0000_0000);
    run_vector(ops);

    // Products fit, wp + g*wc overflows
    ops        = make_operands(1.5, 1.0e308, 1.0e308);
    ref_result = reference_result(ops);
    check_value("infinity reference", ref_result.weight, 64'h7ff0_0000_0000_0000);
    run_vector(ops);

    // Near the top of the range but finite
    run_reals(1.0, 1.7e308, -1.7e308);

    // Second start one cycle later must be dropped
    drive_start(make_operands(0.3, 0.6, -0.4));
    @(negedge CLK);
    operands = make_operands(0.9, -0.7, 0.5);
    @(negedge CLK);
    start = 1'b0;
    wait_result();
    // A stray ready here shows up as a protocol problem
    repeat (8) @(negedge CLK);

    // Random vectors, each after the previous ready
    repeat (vector_count) begin
      run_reals(random_fraction(), random_fraction(), random_fraction());
    end

    repeat (4) @(negedge CLK);
    if (pending.size() != 0) begin
      report_protocol("transactions were still waiting for a result at the end");
    end
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             check_count, value_errors, protocol_errors);
    if ((value_errors == 0) && (protocol_errors == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Hang guard
  initial begin : watchdog
    wait (cycle_count >= max_cycles);
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             check_count, value_errors, protocol_errors);
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim.f
ntm_float_pkg.sv
scalar_float_multiplier.sv
scalar_float_combiner.sv
scalar_float_interpolation.sv
scalar_float_interpolation_tb.sv

// File: Bender.yml
package:
  name: scalar_float_interpolation

dependencies: {}

sources:
  # Package first, then leaf blocks, then the top level
  - ntm_float_pkg.sv
  - scalar_float_multiplier.sv
  - scalar_float_combiner.sv
  - scalar_float_interpolation.sv

  # Testbench only for simulation
  - target: simulation
    files:
      - scalar_float_interpolation_tb.sv
